// ==== Makefile ====
# Verilator build and run of the icache testbench
VERILATOR ?= verilator
TOP       ?= tb_icache
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
FAIL_MSG  ?= >>> FAIL

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q '$(FAIL_MSG)' $(LOG) || ! grep -q 'exit status 0' $(LOG); then \
	  echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
logic/icache_pkg.sv
logic/icache_fetch_stage.sv
logic/icache_arrays.sv
logic/icache_verify_stage.sv
logic/icache_miss_ctrl.sv
logic/icache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_icache.sv

// ==== logic/icache_arrays.sv ====
////////////////////////////////////////////////////////////
// Tag, data, valid and LRU storage, read one set at a time
// Reads return on the next cycle, fills write one word per beat
////////////////////////////////////////////////////////////
module icache_arrays
  import icache_pkg::*;
#(
  parameter int sets_p        = 2 ** index_width_p,
  parameter int block_words_p = block_width_p / word_width_p
)
(
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  rd_v_i,
  input  index_t                                rd_index_i,
  input  logic                                  lru_wr_v_i,
  input  index_t                                lru_wr_index_i,
  input  way_t                                  lru_wr_way_i,
  input  logic                                  fill_wr_v_i,
  input  way_t                                  fill_way_i,
  input  index_t                                fill_index_i,
  input  logic [$clog2(block_words_p)-1:0]      fill_word_sel_i,
  input  word_t                                 fill_data_i,
  input  tag_t                                  fill_tag_i,
  output tag_t [ways_p-1:0]                     rd_tags_o,
  output logic [ways_p-1:0]                     rd_valid_o,
  output way_t                                  rd_lru_o,
  output word_t [ways_p-1:0][block_words_p-1:0] rd_block_o
);

  localparam int sel_w_lp = $clog2(block_words_p);

  tag_t  tag_mem  [ways_p][sets_p];
  word_t data_mem [ways_p][sets_p][block_words_p];

  logic [sets_p-1:0][ways_p-1:0] valid_r;
  logic [sets_p-1:0]             lru_r;
  index_t                        rd_index_r;
  logic                          fill_last;

  // Tag and valid go in with the final word of the block
  assign fill_last = fill_wr_v_i && (fill_word_sel_i == sel_w_lp'(block_words_p - 1));

  //////////////////////////////////////////////////////////
  // Memories
  //////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (fill_wr_v_i)
      data_mem[fill_way_i][fill_index_i][fill_word_sel_i] <= fill_data_i;
    if (fill_last)
      tag_mem[fill_way_i][fill_index_i] <= fill_tag_i;
  end

  // Outputs hold the last set read until the next read
  always_ff @(posedge clk_i)
  begin
    if (rd_v_i)
    begin
      rd_index_r <= rd_index_i;
      for (int w = 0; w < ways_p; w++)
      begin
        rd_tags_o[w] <= tag_mem[w][rd_index_i];
        for (int k = 0; k < block_words_p; k++)
          rd_block_o[w][k] <= data_mem[w][rd_index_i][k];
      end
    end
  end

  //////////////////////////////////////////////////////////
  // Valid and LRU flops
  //////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r <= '0;
      lru_r   <= '0;
    end
    else
    begin
      if (fill_last)
        valid_r[fill_index_i][fill_way_i] <= 1'b1;
      // LRU names the way that was not just used
      if (lru_wr_v_i)
        lru_r[lru_wr_index_i] <= ~lru_wr_way_i;
    end
  end

  // Looked up from the flops so LRU updates show up at once
  assign rd_valid_o = valid_r[rd_index_r];
  assign rd_lru_o   = lru_r[rd_index_r];

endmodule

// ==== logic/icache_fetch_stage.sv ====
////////////////////////////////////////////////////////////
// Input side of the icache: takes fetch requests, starts the
// array read and holds the lookup in the TL stage
////////////////////////////////////////////////////////////
module icache_fetch_stage
  import icache_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         fetch_v_i,
  input  addr_t        fetch_addr_i,
  input  logic         tv_advance_i,
  input  cache_state_e state_i,
  output logic         fetch_ready_o,
  output logic         rd_v_o,
  output index_t       rd_index_o,
  output logic         tl_v_o,
  output addr_t        tl_addr_o
);

  logic  tl_v_r;
  addr_t tl_addr_r;
  logic  tl_load;
  logic  in_recover;

  assign in_recover = (state_i == e_recover);

  // Room in TL when it is empty or its item moves on this cycle
  assign fetch_ready_o = (state_i == e_ready) && (!tl_v_r || tv_advance_i);
  assign tl_load       = fetch_v_i && fetch_ready_o;

  // Read goes out with acceptance; recover refreshes the held lookup
  assign rd_v_o     = tl_load || (in_recover && tl_v_r);
  assign rd_index_o = in_recover ? tl_addr_r[index_lsb_p +: index_width_p]
                                 : fetch_addr_i[index_lsb_p +: index_width_p];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_v_r <= 1'b0;
    else if (tl_load)
      tl_v_r <= 1'b1;
    else if (tv_advance_i)
      tl_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (tl_load)
      tl_addr_r <= fetch_addr_i;
  end

  assign tl_v_o    = tl_v_r;
  assign tl_addr_o = tl_addr_r;

  // The missed lookup sits in TL for the whole fill, nothing replaces it
  a_tl_held_in_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_i == e_miss) |-> (tl_v_r && !tl_load));

endmodule

// ==== logic/icache_miss_ctrl.sv ====
////////////////////////////////////////////////////////////
// Ready/miss/recover control: block request, fill beats and
// the choice of victim way
////////////////////////////////////////////////////////////
module icache_miss_ctrl
  import icache_pkg::*;
#(
  parameter int block_words_p = block_width_p / word_width_p
)
(
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             miss_v_i,
  input  addr_t                            miss_addr_i,
  input  logic [ways_p-1:0]                miss_valid_i,
  input  way_t                             miss_lru_i,
  input  logic                             mem_req_ready_i,
  input  logic                             mem_fill_v_i,
  input  word_t                            mem_fill_data_i,
  output cache_state_e                     state_o,
  output logic                             mem_req_v_o,
  output addr_t                            mem_req_addr_o,
  output logic                             fill_wr_v_o,
  output way_t                             fill_way_o,
  output index_t                           fill_index_o,
  output logic [$clog2(block_words_p)-1:0] fill_word_sel_o,
  output word_t                            fill_data_o,
  output tag_t                             fill_tag_o
);

  localparam int sel_w_lp = $clog2(block_words_p);

  cache_state_e        state_r;
  cache_state_e        state_n;
  logic                req_pend_r;
  logic [sel_w_lp-1:0] beat_r;
  addr_t               blk_addr_r;
  way_t                victim_r;
  way_t                victim;
  logic                start;
  logic                beat;
  logic                last_beat;

  assign start     = (state_r == e_ready) && miss_v_i;
  assign beat      = (state_r == e_miss) && mem_fill_v_i;
  assign last_beat = beat && (beat_r == sel_w_lp'(block_words_p - 1));

  // Empty way first, LRU way when the set is full
  always_comb
  begin
    if (!miss_valid_i[0])
      victim = 1'b0;
    else if (!miss_valid_i[1])
      victim = 1'b1;
    else
      victim = miss_lru_i;
  end

  //////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////
  always_comb
  begin
    case (state_r)
      e_ready:   state_n = start ? e_miss : e_ready;
      e_miss:    state_n = last_beat ? e_recover : e_miss;
      e_recover: state_n = e_ready;
      default:   state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r    <= e_ready;
      req_pend_r <= 1'b0;
      beat_r     <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (start)
        req_pend_r <= 1'b1;
      else if (mem_req_ready_i)
        req_pend_r <= 1'b0;
      // Wraps back to zero after the last word
      if (beat)
        beat_r <= beat_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      blk_addr_r <= {miss_addr_i[addr_width_p-1:index_lsb_p], {index_lsb_p{1'b0}}};
      victim_r   <= victim;
    end
  end

  assign state_o         = state_r;
  assign mem_req_v_o     = req_pend_r;
  assign mem_req_addr_o  = blk_addr_r;
  assign fill_wr_v_o     = beat;
  assign fill_way_o      = victim_r;
  assign fill_index_o    = blk_addr_r[index_lsb_p +: index_width_p];
  assign fill_word_sel_o = beat_r;
  assign fill_data_o     = mem_fill_data_i;
  assign fill_tag_o      = blk_addr_r[tag_lsb_p +: tag_width_p];

  // Memory only returns data for a request that has already gone out
  a_fill_in_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_fill_v_i |-> ((state_r == e_miss) && !req_pend_r));

endmodule

// ==== logic/icache_pkg.sv ====
////////////////////////////////////////////////////////////
// Widths, address fields and types shared by the icache
// Modules take it with a wildcard import in their header
////////////////////////////////////////////////////////////
package icache_pkg;

  // Basic sizes
  parameter int addr_width_p  = 32;
  parameter int word_width_p  = 32;
  parameter int block_words_p = 4;
  parameter int block_width_p = block_words_p * word_width_p;
  parameter int sets_p        = 16;
  parameter int ways_p        = 2;

  // Address layout, low to high: byte, word offset, index, tag
  parameter int byte_offset_width_p = 2;
  parameter int word_offset_width_p = $clog2(block_words_p);
  parameter int index_width_p       = $clog2(sets_p);
  parameter int tag_width_p         = addr_width_p - index_width_p
                                      - word_offset_width_p - byte_offset_width_p;
  parameter int index_lsb_p         = byte_offset_width_p + word_offset_width_p;
  parameter int tag_lsb_p           = index_lsb_p + index_width_p;

  // Cache control states
  typedef enum logic [1:0] {
    e_ready,
    e_miss,
    e_recover
  } cache_state_e;

  typedef logic [addr_width_p-1:0]  addr_t;
  typedef logic [tag_width_p-1:0]   tag_t;
  typedef logic [index_width_p-1:0] index_t;
  typedef logic [word_width_p-1:0]  word_t;

  // One bit is enough to name a way in a 2-way cache
  typedef logic way_t;

endpackage

// ==== logic/icache_top.sv ====
////////////////////////////////////////////////////////////
// 2-way L1 instruction cache, fetch port in, memory port out
////////////////////////////////////////////////////////////
module icache_top
  import icache_pkg::*;
#(
  parameter int sets_p        = icache_pkg::sets_p,
  parameter int block_words_p = icache_pkg::block_words_p
)
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  fetch_v_i,
  input  addr_t fetch_addr_i,
  output logic  fetch_ready_o,
  output logic  data_v_o,
  output word_t data_o,
  input  logic  data_ready_i,
  output logic  mem_req_v_o,
  output addr_t mem_req_addr_o,
  input  logic  mem_req_ready_i,
  input  logic  mem_fill_v_i,
  input  word_t mem_fill_data_i
);

  // Fetch to arrays and verify
  logic   rd_v;
  index_t rd_index;
  logic   tl_v;
  addr_t  tl_addr;

  // Array read results
  tag_t  [ways_p-1:0]                     rd_tags;
  logic  [ways_p-1:0]                     rd_valid;
  way_t                                   rd_lru;
  word_t [ways_p-1:0][block_words_p-1:0]  rd_block;

  // Verify stage outputs
  logic              tv_advance;
  logic              lru_wr_v;
  index_t            lru_wr_index;
  way_t              lru_wr_way;
  logic              miss_v;
  addr_t             miss_addr;
  logic [ways_p-1:0] miss_valid;
  way_t              miss_lru;

  // Miss controller outputs
  cache_state_e                     state;
  logic                             fill_wr_v;
  way_t                             fill_way;
  index_t                           fill_index;
  logic [$clog2(block_words_p)-1:0] fill_word_sel;
  word_t                            fill_data;
  tag_t                             fill_tag;

  icache_fetch_stage u_fetch (
    .clk_i(clk_i), .reset_i(reset_i),
    .fetch_v_i(fetch_v_i), .fetch_addr_i(fetch_addr_i),
    .tv_advance_i(tv_advance), .state_i(state),
    .fetch_ready_o(fetch_ready_o), .rd_v_o(rd_v), .rd_index_o(rd_index),
    .tl_v_o(tl_v), .tl_addr_o(tl_addr)
  );

  icache_arrays #(.sets_p(sets_p), .block_words_p(block_words_p)) u_arrays (
    .clk_i(clk_i), .reset_i(reset_i),
    .rd_v_i(rd_v), .rd_index_i(rd_index),
    .lru_wr_v_i(lru_wr_v), .lru_wr_index_i(lru_wr_index), .lru_wr_way_i(lru_wr_way),
    .fill_wr_v_i(fill_wr_v), .fill_way_i(fill_way), .fill_index_i(fill_index),
    .fill_word_sel_i(fill_word_sel), .fill_data_i(fill_data), .fill_tag_i(fill_tag),
    .rd_tags_o(rd_tags), .rd_valid_o(rd_valid), .rd_lru_o(rd_lru), .rd_block_o(rd_block)
  );

  icache_verify_stage #(.block_words_p(block_words_p)) u_verify (
    .clk_i(clk_i), .reset_i(reset_i),
    .tl_v_i(tl_v), .tl_addr_i(tl_addr),
    .rd_tags_i(rd_tags), .rd_valid_i(rd_valid), .rd_lru_i(rd_lru), .rd_block_i(rd_block),
    .state_i(state), .data_ready_i(data_ready_i),
    .tv_advance_o(tv_advance), .data_v_o(data_v_o), .data_o(data_o),
    .lru_wr_v_o(lru_wr_v), .lru_wr_index_o(lru_wr_index), .lru_wr_way_o(lru_wr_way),
    .miss_v_o(miss_v), .miss_addr_o(miss_addr),
    .miss_valid_o(miss_valid), .miss_lru_o(miss_lru)
  );

  icache_miss_ctrl #(.block_words_p(block_words_p)) u_miss (
    .clk_i(clk_i), .reset_i(reset_i),
    .miss_v_i(miss_v), .miss_addr_i(miss_addr),
    .miss_valid_i(miss_valid), .miss_lru_i(miss_lru),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_fill_v_i(mem_fill_v_i), .mem_fill_data_i(mem_fill_data_i),
    .state_o(state), .mem_req_v_o(mem_req_v_o), .mem_req_addr_o(mem_req_addr_o),
    .fill_wr_v_o(fill_wr_v), .fill_way_o(fill_way), .fill_index_o(fill_index),
    .fill_word_sel_o(fill_word_sel), .fill_data_o(fill_data), .fill_tag_o(fill_tag)
  );

endmodule

// ==== logic/icache_verify_stage.sv ====
////////////////////////////////////////////////////////////
// Tag compare and word select on the TL lookup, then the TV
// register that hands the word to the consumer
////////////////////////////////////////////////////////////
module icache_verify_stage
  import icache_pkg::*;
#(
  parameter int block_words_p = block_width_p / word_width_p
)
(
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  tl_v_i,
  input  addr_t                                 tl_addr_i,
  input  tag_t [ways_p-1:0]                     rd_tags_i,
  input  logic [ways_p-1:0]                     rd_valid_i,
  input  way_t                                  rd_lru_i,
  input  word_t [ways_p-1:0][block_words_p-1:0] rd_block_i,
  input  cache_state_e                          state_i,
  input  logic                                  data_ready_i,
  output logic                                  tv_advance_o,
  output logic                                  data_v_o,
  output word_t                                 data_o,
  output logic                                  lru_wr_v_o,
  output index_t                                lru_wr_index_o,
  output way_t                                  lru_wr_way_o,
  output logic                                  miss_v_o,
  output addr_t                                 miss_addr_o,
  output logic [ways_p-1:0]                     miss_valid_o,
  output way_t                                  miss_lru_o
);

  tag_t                           tl_tag;
  logic [word_offset_width_p-1:0] tl_offset;
  logic [ways_p-1:0]              way_hit;
  logic                           hit;
  way_t                           hit_way;
  logic                           lookup_v;
  logic                           tv_v_r;
  word_t                          tv_word_r;

  assign tl_tag    = tl_addr_i[tag_lsb_p +: tag_width_p];
  assign tl_offset = tl_addr_i[byte_offset_width_p +: word_offset_width_p];

  always_comb
  begin
    for (int w = 0; w < ways_p; w++)
      way_hit[w] = rd_valid_i[w] && (rd_tags_i[w] == tl_tag);
  end

  // With two ways, a hit in way 1 names the way directly
  assign hit     = |way_hit;
  assign hit_way = way_hit[1];

  // Array data only counts in e_ready as it is stale in miss and recover
  assign lookup_v     = tl_v_i && (state_i == e_ready);
  assign tv_advance_o = lookup_v && hit && (!tv_v_r || data_ready_i);

  //////////////////////////////////////////////////////////
  // TV stage
  //////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tv_v_r <= 1'b0;
    else if (tv_advance_o)
      tv_v_r <= 1'b1;
    else if (data_ready_i)
      tv_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (tv_advance_o)
      tv_word_r <= rd_block_i[hit_way][tl_offset];
  end

  assign data_v_o = tv_v_r;
  assign data_o   = tv_word_r;

  // Hits refresh the LRU as they move into TV
  assign lru_wr_v_o     = tv_advance_o;
  assign lru_wr_index_o = tl_addr_i[index_lsb_p +: index_width_p];
  assign lru_wr_way_o   = hit_way;

  assign miss_v_o     = lookup_v && !hit;
  assign miss_addr_o  = tl_addr_i;
  assign miss_valid_o = rd_valid_i;
  assign miss_lru_o   = rd_lru_i;

  // A block is filled only on a miss, so it sits in at most one way
  a_one_way_hit: assert property (@(posedge clk_i) disable iff (reset_i)
    lookup_v |-> $onehot0(way_hit));

endmodule

// ==== testbench/icache_stimulus.txt ====
# address  expected_word  miss(1)/hit(0)  cycles_data_ready_low
# expected word = address XOR c0de0000
00001004 c0de1004 1 0
00001000 c0de1000 0 0
00001008 c0de1008 0 4
0000100c c0de100c 0 0
00002024 c0de2024 1 0
00003028 c0de3028 1 0
0000202c c0de202c 0 0
00004020 c0de4020 1 0
00002020 c0de2020 0 0
0000302c c0de302c 1 2
12345670 d2ea5670 1 5
12345674 d2ea5674 0 3
12345678 d2ea5678 0 0
0000100c c0de100c 0 0
00001000 c0de1000 0 0
00001004 c0de1004 0 0
1234567c d2ea567c 0 0
000000f0 c0de00f0 1 0
fffffffc 3f21fffc 1 1
000000f4 c0de00f4 0 0
fffffff0 3f21fff0 0 0

// ==== testbench/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////
// Testbench clock, 10 ns period, and an 8-cycle reset
////////////////////////////////////////////////////////////
module tb_clock_gen
(
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial
  begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== testbench/tb_icache.sv ====
////////////////////////////////////////////////////////////
// Replays the stimulus file against a memory model and checks
// every response and memory request of the icache
////////////////////////////////////////////////////////////
module tb_icache;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int cycles_per_fetch_lp = 200;
  localparam int block_words_lp      = 4;

  logic        clk;
  logic        reset;
  logic        fetch_v_i;
  logic [31:0] fetch_addr_i;
  logic        fetch_ready_o;
  logic        data_v_o;
  logic [31:0] data_o;
  logic        data_ready_i;
  logic        mem_req_v_o;
  logic [31:0] mem_req_addr_o;
  logic        mem_req_ready_i;
  logic        mem_fill_v_i;
  logic [31:0] mem_fill_data_i;

  // Stimulus with one entry per fetch
  logic [31:0] stim_addr[$];
  logic [31:0] stim_word[$];
  logic        stim_miss[$];
  int          stim_stall[$];
  int          n_lines;
  int          setup_errors;
  int          end_errors;

  // Checker state
  logic [31:0] req_addr_q[$];
  int          req_at_accept[$];
  int          acc_idx;
  int          resp_idx;
  int          held;
  logic        was_held;
  logic        test_bad;
  int          errors;
  int          tests_run;
  int          tests_failed;

  tb_clock_gen clock_gen (
    .clk_o(clk),
    .reset_o(reset)
  );

  icache_top DUT (
    .clk_i(clk), .reset_i(reset),
    .fetch_v_i(fetch_v_i), .fetch_addr_i(fetch_addr_i), .fetch_ready_o(fetch_ready_o),
    .data_v_o(data_v_o), .data_o(data_o), .data_ready_i(data_ready_i),
    .mem_req_v_o(mem_req_v_o), .mem_req_addr_o(mem_req_addr_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_fill_v_i(mem_fill_v_i), .mem_fill_data_i(mem_fill_data_i)
  );

  function automatic logic [31:0] block_base(input logic [31:0] addr);
    return {addr[31:4], 4'b0000};
  endfunction

  task automatic load_stimulus();
    int          fd;
    string       line;
    logic [31:0] addr;
    logic [31:0] word;
    int          miss;
    int          stall;
    fd = $fopen("testbench/icache_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the stimulus file");
      setup_errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        // Comment lines start with #
        if (line.len() > 0 && line[0] != "#")
        begin
          if ($sscanf(line, "%h %h %d %d", addr, word, miss, stall) == 4)
          begin
            stim_addr.push_back(addr);
            stim_word.push_back(word);
            stim_miss.push_back(miss != 0);
            stim_stall.push_back(stall);
          end
        end
      end
      $fclose(fd);
    end
    n_lines = stim_addr.size();
    if (n_lines == 0)
    begin
      $display("The stimulus file holds no fetches");
      setup_errors++;
    end
  endtask

  // Requests between this fetch's acceptance and the next one belong to it
  task automatic close_test();
    int first;
    int last;
    int want;
    int r;
    first = req_at_accept[resp_idx];
    if (acc_idx > resp_idx + 1)
      last = req_at_accept[resp_idx + 1];
    else
      last = req_addr_q.size();
    want = stim_miss[resp_idx] ? 1 : 0;
    if (last - first != want)
    begin
      $display("Test %0d made %0d memory requests where %0d were expected",
               resp_idx, last - first, want);
      errors++;
      test_bad = 1'b1;
    end
    for (r = first; r < last; r++)
    begin
      if (req_addr_q[r] !== block_base(stim_addr[resp_idx]))
      begin
        $display("ERROR at %0d ns: mem_req_addr_o = %h, expected %h",
                 $time, req_addr_q[r], block_base(stim_addr[resp_idx]));
        errors++;
        test_bad = 1'b1;
      end
    end
    $display("Test %0d: fetch %h, %s, %s", resp_idx, stim_addr[resp_idx],
             stim_miss[resp_idx] ? "miss" : "hit", test_bad ? "failed" : "ok");
    if (test_bad)
      tests_failed++;
    tests_run++;
    test_bad = 1'b0;
    held     = 0;
    resp_idx++;
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model with a random 0 to 3 cycle wait before ready
  ////////////////////////////////////////////////////////////
  initial
  begin : memory_model
    logic [31:0] blk;
    int unsigned wait_cycles;
    int          k;
    void'($urandom(32'hd195_c6a9));
    mem_req_ready_i = 1'b0;
    mem_fill_v_i    = 1'b0;
    mem_fill_data_i = '0;
    forever
    begin
      @(posedge clk);
      if (mem_req_v_o)
      begin
        wait_cycles = $urandom % 4;
        repeat (wait_cycles) @(posedge clk);
        mem_req_ready_i <= 1'b1;
        @(posedge clk);
        mem_req_ready_i <= 1'b0;
        blk = mem_req_addr_o;
        // Word k of a block is its byte address XOR c0de_0000
        for (k = 0; k < block_words_lp; k++)
        begin
          mem_fill_v_i    <= 1'b1;
          mem_fill_data_i <= (blk + 32'(4 * k)) ^ 32'hc0de_0000;
          @(posedge clk);
        end
        mem_fill_v_i <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Fetch driver and response checker
  ////////////////////////////////////////////////////////////
  initial
  begin
    fetch_v_i    = 1'b0;
    fetch_addr_i = '0;
    data_ready_i = 1'b0;
    acc_idx      = 0;
    resp_idx     = 0;
    held         = 0;
    was_held     = 1'b0;
    test_bad     = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    forever
    begin
      @(posedge clk);
      if (!reset)
      begin
        if (mem_req_v_o && mem_req_ready_i)
          req_addr_q.push_back(mem_req_addr_o);

        // A miss in service holds off new fetches
        if (fetch_ready_o && (mem_req_v_o || mem_fill_v_i))
        begin
          $display("ERROR at %0d ns: fetch_ready_o = 1, expected 0", $time);
          errors++;
          test_bad = 1'b1;
        end

        if (fetch_v_i && fetch_ready_o)
        begin
          req_at_accept.push_back(req_addr_q.size());
          acc_idx++;
        end

        if (was_held && !data_v_o)
        begin
          $display("Response for test %0d was dropped while data_ready_i was low", resp_idx);
          errors++;
          test_bad = 1'b1;
        end
        was_held = data_v_o && !data_ready_i;

        if (data_v_o)
        begin
          if (resp_idx >= acc_idx)
          begin
            if (data_ready_i)
            begin
              $display("Response at %0d ns with no fetch outstanding", $time);
              errors++;
            end
          end
          else
          begin
            if (data_o !== stim_word[resp_idx])
            begin
              $display("ERROR at %0d ns: data_o = %h, expected %h",
                       $time, data_o, stim_word[resp_idx]);
              errors++;
              test_bad = 1'b1;
            end
            if (data_ready_i)
              close_test();
            else
              held++;
          end
        end

        // Next fetch goes out as soon as the previous one is taken
        fetch_v_i <= (acc_idx < n_lines);
        if (acc_idx < n_lines)
          fetch_addr_i <= stim_addr[acc_idx];
        data_ready_i <= !((resp_idx < n_lines) && (held < stim_stall[resp_idx]));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Run control, timeout and summary
  ////////////////////////////////////////////////////////////
  initial
  begin
    int   cycles;
    int   limit;
    int   want_reqs;
    logic timed_out;
    setup_errors = 0;
    end_errors   = 0;
    cycles       = 0;
    want_reqs    = 0;
    load_stimulus();
    limit = cycles_per_fetch_lp * n_lines;
    @(negedge reset);
    while (resp_idx < n_lines && cycles < limit)
    begin
      @(negedge clk);
      cycles++;
    end
    timed_out = (resp_idx < n_lines);
    if (timed_out)
      $display("Timeout after %0d cycles, %0d of %0d fetches answered",
               cycles, resp_idx, n_lines);
    else
    begin
      // Let any extra response or request show up
      repeat (10) @(negedge clk);
      foreach (stim_miss[i])
      begin
        if (stim_miss[i])
          want_reqs++;
      end
      if (req_addr_q.size() != want_reqs)
      begin
        $display("Saw %0d memory requests in total where %0d were expected",
                 req_addr_q.size(), want_reqs);
        end_errors++;
      end
    end
    $display("Summary: %0d tests, %0d failed, %0d errors",
             tests_run, tests_failed, errors + setup_errors + end_errors);
    if (!timed_out && errors == 0 && setup_errors == 0 && end_errors == 0
        && tests_failed == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule
